// File: mips_core.f
+incdir+hdl
hdl/mips_pkg.sv
hdl/regfile.sv
hdl/id_stage.sv
hdl/ex_stage.sv
hdl/mips_core.sv
tests/wb_checker.sv
tests/tb_mips_core.sv

// File: run_sim.sh
#!/bin/sh
# build and run the mips_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f mips_core.f --top-module tb_mips_core -Mdir "$OBJ_DIR"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ_DIR/Vtb_mips_core" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
    exit 1
fi
exit 0

// File: tests/tb_mips_core.sv
`timescale 1ns/1ps

module tb_mips_core;
    localparam int PHASE_LEN  = 200;
    localparam int N_PHASES   = 5;    // instruction phases after the reset test
    localparam int MAX_CYCLES = N_PHASES * PHASE_LEN * 2 + 50;

    // encodings packed 6 bits per entry
    localparam logic [23:0] IMM_LOGIC_OPS = {6'h0c, 6'h0d, 6'h0e, 6'h0f};
    localparam logic [23:0] IMM_ARITH_OPS = {6'h08, 6'h09, 6'h0a, 6'h0b};
    localparam logic [59:0] RTYPE_FNS     = {6'h20, 6'h21, 6'h22, 6'h23, 6'h24,
                                             6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b};
    localparam logic [35:0] SHIFT_FNS     = {6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07};

    integer      seed;
    int          cycle_cnt;
    int          test_idx;
    int          err_cnt;
    int          check_cnt;
    logic        clk;
    logic        rst_n;
    logic        inst_valid;
    logic [31:0] inst;
    logic        wb_we;
    logic [4:0]  wb_waddr;
    logic [31:0] wb_wdata;
    logic        report_req;
    logic        end_run;

    mips_core uut (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .inst_valid_i (inst_valid),
        .inst_i       (inst),
        .wb_we_o      (wb_we),
        .wb_waddr_o   (wb_waddr),
        .wb_wdata_o   (wb_wdata)
    );

    wb_checker chk (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .inst_valid_i (inst_valid),
        .inst_i       (inst),
        .wb_we_i      (wb_we),
        .wb_waddr_i   (wb_waddr),
        .wb_wdata_i   (wb_wdata),
        .test_idx_i   (test_idx),
        .report_i     (report_req),
        .end_run_i    (end_run),
        .err_cnt_o    (err_cnt),
        .check_cnt_o  (check_cnt)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test FAILED");
            $finish;
        end
    end

    function automatic int rnd(int n);
        return int'($unsigned($random(seed)) % $unsigned(n));
    endfunction

    function automatic logic [4:0] pick_reg();
        if (rnd(4) != 0) begin
            return 5'(rnd(4));  // mostly r0..r3 so neighbours depend on each other
        end
        return 5'(rnd(32));
    endfunction

    function automatic logic [31:0] gen_legal(int kind);
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [5:0]  fn;
        logic [15:0] imm;
        rs  = pick_reg();
        rt  = pick_reg();
        rd  = pick_reg();
        imm = (rnd(8) == 0) ? 16'h8000 : 16'($random(seed));
        case (kind)
            1: return {IMM_LOGIC_OPS[6*rnd(4) +: 6], rs, rt, imm};
            2: return {IMM_ARITH_OPS[6*rnd(4) +: 6], rs, rt, imm};
            3: return {6'h00, rs, rt, rd, 5'd0, RTYPE_FNS[6*rnd(10) +: 6]};
            default: begin
                fn = SHIFT_FNS[6*rnd(6) +: 6];
                return {6'h00, rs, rt, rd, (fn[2] ? 5'd0 : 5'(rnd(32))), fn};
            end
        endcase
    endfunction

    function automatic logic [31:0] gen_inst(int phase);
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        if (phase < N_PHASES) begin
            return gen_legal(phase);
        end
        rs = pick_reg();
        rt = pick_reg();
        rd = pick_reg();
        case (rnd(8))
            0: return 32'h0000_000f;                                // sync
            1: return {6'h33, rs, rt, 16'($random(seed))};          // pref
            2: return {6'(16 + rnd(48)), 26'($random(seed))};       // unused opcodes
            3: return {6'h00, rs, rt, rd, 5'(1 + rnd(31)), RTYPE_FNS[6*rnd(10) +: 6]};
            default: return gen_legal(1 + rnd(4));
        endcase
    endfunction

    task automatic idle(int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #1;
            inst_valid = 1'b0;
        end
    endtask

    task automatic end_test();
        @(posedge clk);
        #1;
        report_req = 1'b1;
        @(posedge clk);
        #1;
        report_req = 1'b0;
    endtask

    task automatic run_phase(int phase);
        int n;
        int gap_div;
        n       = 0;
        gap_div = (phase == N_PHASES) ? 4 : 8;
        while (n < PHASE_LEN) begin
            @(posedge clk);
            #1;
            if (rnd(gap_div) == 0) begin
                inst_valid = 1'b0;
                inst       = $random(seed);  // garbage while not valid
            end else begin
                inst_valid = 1'b1;
                inst       = gen_inst(phase);
                n++;
            end
        end
    endtask

    initial begin
        seed       = 32'hf1f9_eced;
        cycle_cnt  = 0;
        clk        = 1'b0;
        rst_n      = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        test_idx   = 0;
        report_req = 1'b0;
        end_run    = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        idle(4);
        end_test();
        for (int p = 1; p <= N_PHASES; p++) begin
            test_idx = p;
            run_phase(p);
            idle(4);  // drain the pipeline before the report
            end_test();
        end
        end_run = 1'b1;
        @(posedge clk);
        #1;
        end_run = 1'b0;
        @(posedge clk);
        #1;
        $display("tests %0d, checks %0d, errors %0d", N_PHASES + 1, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: tests/wb_checker.sv
`timescale 1ns/1ps

module wb_checker (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        inst_valid_i,
    input  logic [31:0] inst_i,
    input  logic        wb_we_i,
    input  logic [4:0]  wb_waddr_i,
    input  logic [31:0] wb_wdata_i,
    input  int          test_idx_i,
    input  logic        report_i,
    input  logic        end_run_i,
    output int          err_cnt_o,
    output int          check_cnt_o
);
    typedef struct packed {
        logic        we;
        logic [2:0]  test;
        logic [4:0]  addr;
        logic [31:0] data;
    } wr_t;

    logic [31:0] regs [32];  // architectural state in program order
    wr_t         exp_q [$];
    wr_t         got;
    wr_t         nxt;
    int          checks [6];
    int          errs [6];
    int          err_total;
    int          check_total;

    function automatic string test_name(int idx);
        case (idx)
            0: return "reset";
            1: return "imm_logic";
            2: return "imm_arith";
            3: return "rtype";
            4: return "shifts";
            default: return "bubble_bypass";
        endcase
    endfunction

    function automatic void count_error(int idx);
        errs[idx]++;
        err_total++;
    endfunction

    function automatic wr_t model_exec(logic [31:0] inst);
        logic [5:0]  fn;
        logic [4:0]  sa;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] zimm;
        logic [31:0] simm;
        wr_t         w;
        fn   = inst[5:0];
        sa   = inst[10:6];
        a    = regs[inst[25:21]];
        b    = regs[inst[20:16]];
        zimm = {16'h0, inst[15:0]};
        simm = {{16{inst[15]}}, inst[15:0]};
        w    = '{we: 1'b1, test: 3'd0, addr: inst[20:16], data: '0};
        case (inst[31:26])
            6'h08, 6'h09: w.data = a + simm;
            6'h0a:        w.data = {31'd0, $signed(a) < $signed(simm)};
            6'h0b:        w.data = {31'd0, a < simm};
            6'h0c:        w.data = a & zimm;
            6'h0d:        w.data = a | zimm;
            6'h0e:        w.data = a ^ zimm;
            6'h0f:        w.data = {inst[15:0], 16'h0};
            6'h00: begin
                w.addr = inst[15:11];
                case (fn)
                    6'h00:        w.data = b << sa;
                    6'h02:        w.data = b >> sa;
                    6'h03:        w.data = $signed(b) >>> sa;
                    6'h04:        w.data = b << a[4:0];
                    6'h06:        w.data = b >> a[4:0];
                    6'h07:        w.data = $signed(b) >>> a[4:0];
                    6'h20, 6'h21: w.data = a + b;
                    6'h22, 6'h23: w.data = a - b;
                    6'h24:        w.data = a & b;
                    6'h25:        w.data = a | b;
                    6'h26:        w.data = a ^ b;
                    6'h27:        w.data = ~(a | b);
                    6'h2a:        w.data = {31'd0, $signed(a) < $signed(b)};
                    6'h2b:        w.data = {31'd0, a < b};
                    default:      w.we = 1'b0;  // sync and undefined functions
                endcase
                // only the shamt shifts may carry a shift amount
                if (sa != '0 && !(fn inside {6'h00, 6'h02, 6'h03})) begin
                    w.we = 1'b0;
                end
            end
            default: w.we = 1'b0;  // pref and unused opcodes
        endcase
        if (w.addr == '0) begin
            w.we = 1'b0;
        end
        return w;
    endfunction

    always @(posedge clk) begin
        if (!rst_n_i || test_idx_i == 0) begin
            checks[0]++;
            check_total++;
            if (wb_we_i !== 1'b0) begin
                $display("CHECK FAILED reset: expected wb_we_o = 0, actual wb_we_o = %b",
                         wb_we_i);
                count_error(0);
            end
            if (!rst_n_i) begin
                for (int i = 0; i < 32; i++) begin
                    regs[i] = '0;
                end
                exp_q.delete();
            end
        end else begin
            if (wb_we_i) begin
                if (exp_q.size() == 0) begin
                    $display("ERROR %s: write to r%0d appeared with no writeback expected",
                             test_name(test_idx_i), wb_waddr_i);
                    count_error(test_idx_i);
                end else begin
                    got = exp_q.pop_front();
                    checks[got.test]++;
                    check_total++;
                    if (wb_waddr_i !== got.addr || wb_wdata_i !== got.data) begin
                        $display("CHECK FAILED %s: expected r%0d = %08h, actual r%0d = %08h",
                                 test_name(int'(got.test)), got.addr, got.data,
                                 wb_waddr_i, wb_wdata_i);
                        count_error(int'(got.test));
                    end
                end
            end
            if (inst_valid_i) begin
                nxt = model_exec(inst_i);
                if (nxt.we) begin
                    regs[nxt.addr] = nxt.data;
                    nxt.test       = test_idx_i[2:0];
                    exp_q.push_back(nxt);
                end
            end
        end
        if (report_i) begin
            $display("test %0s: %0d checks, %0d errors", test_name(test_idx_i),
                     checks[test_idx_i], errs[test_idx_i]);
        end
        if (end_run_i && exp_q.size() != 0) begin
            $display("ERROR: %0d expected writebacks never appeared", exp_q.size());
            err_total += exp_q.size();
        end
    end

    assign err_cnt_o   = err_total;
    assign check_cnt_o = check_total;

endmodule

// File: hdl/mips_core.sv
`timescale 1ns/1ps

module mips_core (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                inst_valid_i,
    input  mips_pkg::word_t     inst_i,
    output logic                wb_we_o,
    output mips_pkg::reg_addr_t wb_waddr_o,
    output mips_pkg::word_t     wb_wdata_o
);
    import mips_pkg::*;

    reg_addr_t raddr_a;
    reg_addr_t raddr_b;
    word_t     rdata_a;
    word_t     rdata_b;
    id_ex_t    id_ex;
    wb_t       ex_fwd;
    wb_t       wb;

    id_stage u_id (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .raddr_a_o    (raddr_a),
        .raddr_b_o    (raddr_b),
        .rdata_a_i    (rdata_a),
        .rdata_b_i    (rdata_b),
        .ex_fwd_i     (ex_fwd),
        .wb_fwd_i     (wb),
        .id_ex_o      (id_ex)
    );

    ex_stage u_ex (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .id_ex_i  (id_ex),
        .ex_fwd_o (ex_fwd),
        .wb_o     (wb)
    );

    // wb record is also the regfile write port
    regfile u_rf (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .raddr_a_i (raddr_a),
        .raddr_b_i (raddr_b),
        .rdata_a_o (rdata_a),
        .rdata_b_o (rdata_b),
        .wb_i      (wb)
    );

    assign wb_we_o    = wb.we;
    assign wb_waddr_o = wb.waddr;
    assign wb_wdata_o = wb.wdata;

endmodule

// File: hdl/ex_stage.sv
`timescale 1ns/1ps
`include "mips_config.svh"

module ex_stage (
    input  logic              clk,
    input  logic              rst_n_i,
    input  mips_pkg::id_ex_t  id_ex_i,
    output mips_pkg::wb_t     ex_fwd_o,
    output mips_pkg::wb_t     wb_o
);
    import mips_pkg::*;

    logic [`MIPS_SHAMT_W-1:0] sh;
    word_t                    result;
    wb_t                      wb_q;

    assign sh = id_ex_i.a[`MIPS_SHAMT_W-1:0];  // low bits of rs or shamt

    always_comb begin
        case (id_ex_i.alu_op)
            ALU_AND:  result = id_ex_i.a & id_ex_i.b;
            ALU_OR:   result = id_ex_i.a | id_ex_i.b;
            ALU_XOR:  result = id_ex_i.a ^ id_ex_i.b;
            ALU_NOR:  result = ~(id_ex_i.a | id_ex_i.b);
            ALU_LUI:  result = id_ex_i.b;
            ALU_ADD:  result = id_ex_i.a + id_ex_i.b;  // wraps
            ALU_SUB:  result = id_ex_i.a - id_ex_i.b;
            ALU_SLT:  result = word_t'($signed(id_ex_i.a) < $signed(id_ex_i.b));
            ALU_SLTU: result = word_t'(id_ex_i.a < id_ex_i.b);
            ALU_SLL:  result = id_ex_i.b << sh;
            ALU_SRL:  result = id_ex_i.b >> sh;
            ALU_SRA:  result = word_t'($signed(id_ex_i.b) >>> sh);
            default:  result = '0;
        endcase
    end

    // same-cycle result for the decode bypass
    assign ex_fwd_o = '{we: id_ex_i.we, waddr: id_ex_i.waddr, wdata: result};

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_q <= '0;
        end else begin
            wb_q <= ex_fwd_o;
        end
    end

    assign wb_o = wb_q;

    a_wb_we_known: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        !$isunknown(wb_q.we)
    ) else $error("writeback enable is X or Z");

endmodule

// File: hdl/id_stage.sv
`timescale 1ns/1ps
`include "mips_config.svh"

module id_stage (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                inst_valid_i,
    input  mips_pkg::word_t     inst_i,
    output mips_pkg::reg_addr_t raddr_a_o,
    output mips_pkg::reg_addr_t raddr_b_o,
    input  mips_pkg::word_t     rdata_a_i,
    input  mips_pkg::word_t     rdata_b_i,
    input  mips_pkg::wb_t       ex_fwd_i,
    input  mips_pkg::wb_t       wb_fwd_i,
    output mips_pkg::id_ex_t    id_ex_o
);
    import mips_pkg::*;

    opcode_e                  opcode;
    funct_e                   funct;
    reg_addr_t                rs;
    reg_addr_t                rt;
    reg_addr_t                rd;
    logic [`MIPS_SHAMT_W-1:0] shamt;
    logic [15:0]              imm16;

    logic      dec_we;
    reg_addr_t dec_waddr;
    alu_op_e   dec_op;
    logic      read_a;
    logic      read_b;
    word_t     imm;
    word_t     op_a;
    word_t     op_b;
    id_ex_t    id_ex_q;

    // youngest producer wins
    function automatic word_t bypass(reg_addr_t addr, word_t rf_data,
                                     wb_t ex_fwd, wb_t wb_fwd);
        if (ex_fwd.we && ex_fwd.waddr == addr) begin
            return ex_fwd.wdata;
        end else if (wb_fwd.we && wb_fwd.waddr == addr) begin
            return wb_fwd.wdata;
        end
        return rf_data;
    endfunction

    function automatic alu_op_e funct_to_op(funct_e f);
        case (f)
            FN_SLLV:         return ALU_SLL;
            FN_SRLV:         return ALU_SRL;
            FN_SRAV:         return ALU_SRA;
            FN_ADD, FN_ADDU: return ALU_ADD;  // no overflow trap
            FN_SUB, FN_SUBU: return ALU_SUB;
            FN_AND:          return ALU_AND;
            FN_OR:           return ALU_OR;
            FN_XOR:          return ALU_XOR;
            FN_NOR:          return ALU_NOR;
            FN_SLT:          return ALU_SLT;
            FN_SLTU:         return ALU_SLTU;
            default:         return ALU_NOP;  // sync and unknown
        endcase
    endfunction

    assign opcode = opcode_e'(inst_i[31:26]);
    assign rs     = inst_i[25:21];
    assign rt     = inst_i[20:16];
    assign rd     = inst_i[15:11];
    assign shamt  = inst_i[10:6];
    assign funct  = funct_e'(inst_i[5:0]);
    assign imm16  = inst_i[15:0];

    always_comb begin
        dec_op    = ALU_NOP;
        dec_waddr = rt;     // immediate forms write rt
        read_a    = 1'b1;
        read_b    = 1'b0;
        imm       = '0;
        case (opcode)
            OP_ANDI: begin
                dec_op = ALU_AND;
                imm    = {16'h0, imm16};
            end
            OP_ORI: begin
                dec_op = ALU_OR;
                imm    = {16'h0, imm16};
            end
            OP_XORI: begin
                dec_op = ALU_XOR;
                imm    = {16'h0, imm16};
            end
            OP_LUI: begin
                dec_op = ALU_LUI;
                imm    = {imm16, 16'h0};
            end
            OP_ADDI, OP_ADDIU: begin
                dec_op = ALU_ADD;
                imm    = {{16{imm16[15]}}, imm16};
            end
            OP_SLTI: begin
                dec_op = ALU_SLT;
                imm    = {{16{imm16[15]}}, imm16};
            end
            OP_SLTIU: begin
                dec_op = ALU_SLTU;
                imm    = {{16{imm16[15]}}, imm16};
            end
            OP_SPECIAL: begin
                dec_waddr = rd;
                read_b    = 1'b1;
                case (funct)
                    FN_SLL, FN_SRL, FN_SRA: begin
                        read_a = 1'b0;           // shamt goes in slot a
                        imm    = word_t'(shamt);
                        dec_op = (funct == FN_SLL) ? ALU_SLL :
                                 (funct == FN_SRL) ? ALU_SRL : ALU_SRA;
                    end
                    default: begin
                        if (shamt == '0) begin
                            dec_op = funct_to_op(funct);
                        end
                    end
                endcase
            end
            default: ;  // pref and the rest become bubbles
        endcase
    end

    assign dec_we = inst_valid_i && (dec_op != ALU_NOP) && (dec_waddr != '0);

    assign raddr_a_o = rs;
    assign raddr_b_o = rt;

    assign op_a = read_a ? bypass(rs, rdata_a_i, ex_fwd_i, wb_fwd_i) : imm;
    assign op_b = read_b ? bypass(rt, rdata_b_i, ex_fwd_i, wb_fwd_i) : imm;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            id_ex_q <= '0;
        end else begin
            id_ex_q <= '{we: dec_we, waddr: dec_waddr, a: op_a, b: op_b, alu_op: dec_op};
        end
    end

    assign id_ex_o = id_ex_q;

    a_valid_known: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        !$isunknown(inst_valid_i)
    ) else $error("inst_valid_i is X or Z");

endmodule

// File: hdl/regfile.sv
`timescale 1ns/1ps
`include "mips_config.svh"

module regfile (
    input  logic                clk,
    input  logic                rst_n_i,
    input  mips_pkg::reg_addr_t raddr_a_i,
    input  mips_pkg::reg_addr_t raddr_b_i,
    output mips_pkg::word_t     rdata_a_o,
    output mips_pkg::word_t     rdata_b_o,
    input  mips_pkg::wb_t       wb_i
);
    import mips_pkg::*;

    word_t regs [`MIPS_REG_NUM];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `MIPS_REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.we && wb_i.waddr != '0) begin
            regs[wb_i.waddr] <= wb_i.wdata;
        end
    end

    // r0 hardwired
    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

    // decode must have turned any r0 destination into a bubble
    a_no_r0_write: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        wb_i.we |-> wb_i.waddr != '0
    ) else $error("write to r0 reached the register file");

endmodule

// File: hdl/mips_pkg.sv
`include "mips_config.svh"

package mips_pkg;

    typedef logic [`MIPS_WORD_W-1:0]     word_t;
    typedef logic [`MIPS_REG_ADDR_W-1:0] reg_addr_t;

    // primary opcodes, inst[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDI    = 6'h08,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f
    } opcode_e;

    // function field under SPECIAL, inst[5:0]
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_SLLV = 6'h04,
        FN_SRLV = 6'h06,
        FN_SRAV = 6'h07,
        FN_SYNC = 6'h0f,
        FN_ADD  = 6'h20,
        FN_ADDU = 6'h21,
        FN_SUB  = 6'h22,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_e;

    typedef enum logic [3:0] {
        ALU_NOP, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_LUI, ALU_ADD,
        ALU_SUB, ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA
    } alu_op_e;

    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        word_t     a;      // rs, or shift amount
        word_t     b;      // rt, or extended immediate
        alu_op_e   alu_op;
    } id_ex_t;

    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        word_t     wdata;
    } wb_t;

endpackage

// File: hdl/mips_config.svh
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

`define MIPS_WORD_W     32
`define MIPS_REG_NUM    32
`define MIPS_REG_ADDR_W 5

// shamt field and shift amount width
`define MIPS_SHAMT_W    5

`endif
